// File: Bender.yml
package:
  name: screen

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - screen_pkg.sv
      - entry_ctrl_if.sv
      - vga_timing.sv
      - entry_fsm.sv
      - tile_store.sv
      - tile_renderer.sv
      - screen_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_screen.sv

// File: entry_ctrl_if.sv
`default_nettype none

interface entry_ctrl_if;
   import screen_pkg::*;

   entry_state_t state;
   logic save;
   logic clear;
   // no live tile left unset
   logic all_set;

   modport sequencer (
      output state,
      output save,
      output clear,
      input  all_set
   );

   modport store (
      input  state,
      input  save,
      input  clear,
      output all_set
   );

endinterface

`default_nettype wire

// File: entry_fsm.sv
`default_nettype none

module entry_fsm (
   input  wire             pclk,
   input  wire             rst,
   input  wire             enter_i,
   entry_ctrl_if.sequencer ctrl
);
   import screen_pkg::*;

   entry_state_t state_q;
   entry_state_t state_d;
   logic advance;

   // enter only counts once every live tile has a colour
   assign advance = enter_i && ctrl.all_set;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ENTER_FRONT: begin
            if (advance) begin
               state_d = CLEAR;
            end
         end
         // one cycle to bank the front face
         CLEAR: begin
            state_d = ENTER_BACK;
         end
         ENTER_BACK: begin
            if (advance) begin
               state_d = DONE;
            end
         end
         DONE: begin
            state_d = DONE;
         end
         default: begin
            state_d = ENTER_FRONT;
         end
      endcase
   end

   always_ff @(posedge pclk or posedge rst) begin
      if (rst) begin
         state_q <= ENTER_FRONT;
      end else begin
         state_q <= state_d;
      end
   end

   assign ctrl.state = state_q;

   // both strobes last exactly the single CLEAR cycle
   assign ctrl.save = (state_q == CLEAR);
   assign ctrl.clear = (state_q == CLEAR);

endmodule

`default_nettype wire

// File: screen_config.svh
`ifndef SCREEN_CONFIG_SVH
`define SCREEN_CONFIG_SVH

////////////////////////////////////////
// raster timing, 640x480 at 60 Hz
////////////////////////////////////////
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

////////////////////////////////////////
// tile grid
////////////////////////////////////////
// top-left corner of the grid
`define GRID_X0 220
`define GRID_Y0 140
`define TILE_SIZE 50
`define BORDER 2
`define GRID_COLS 4
`define NUM_TILES 12

// wishbone widths
`define WB_ADR_W 5
`define WB_DAT_W 8

`endif

// File: screen_pkg.sv
`default_nettype none

`include "screen_config.svh"

package screen_pkg;

   typedef logic [9:0] coord_t;
   typedef logic [11:0] rgb_t;
   typedef logic [2:0] color_code_t;
   typedef logic [3:0] tile_idx_t;
   typedef logic [`WB_ADR_W-1:0] wb_adr_t;
   typedef logic [`WB_DAT_W-1:0] wb_dat_t;

   typedef enum logic [1:0] {
      ENTER_FRONT,
      CLEAR,
      ENTER_BACK,
      DONE
   } entry_state_t;

   // fixed colours
   localparam rgb_t HIGHLIGHT = 12'h60c;
   localparam rgb_t BACKGROUND = 12'hffc;
   localparam color_code_t UNSET_CODE = 3'd7;

   // code 6 has no colour and shows like an unset tile
   function automatic rgb_t color_to_rgb(input color_code_t code);
      rgb_t rgb;
      case (code)
         3'd0: rgb = 12'hf00;
         3'd1: rgb = 12'h0f0;
         3'd2: rgb = 12'h00f;
         3'd3: rgb = 12'hfff;
         3'd4: rgb = 12'hf90;
         3'd5: rgb = 12'hff0;
         default: rgb = 12'h000;
      endcase
      return rgb;
   endfunction

endpackage

`default_nettype wire

// File: screen_top.sv
`default_nettype none

`include "screen_config.svh"

module screen_top (
   input  wire                       pclk,
   input  wire                       rst,
   input  wire                       enter_i,
   input  wire screen_pkg::tile_idx_t cursor_i,
   input  wire                       wb_cyc_i,
   input  wire                       wb_stb_i,
   input  wire                       wb_we_i,
   input  wire screen_pkg::wb_adr_t  wb_adr_i,
   input  wire screen_pkg::wb_dat_t  wb_dat_i,
   output screen_pkg::wb_dat_t       wb_dat_o,
   output logic                      wb_ack_o,
   output screen_pkg::entry_state_t  state_o,
   output logic                      hsync_o,
   output logic                      vsync_o,
   output logic [3:0]                vga_red_o,
   output logic [3:0]                vga_green_o,
   output logic [3:0]                vga_blue_o
);
   import screen_pkg::*;

   coord_t h_cnt;
   coord_t v_cnt;
   logic active;
   logic hsync_raw;
   logic vsync_raw;
   color_code_t tile_codes [`NUM_TILES];
   rgb_t rgb;

   entry_ctrl_if ctrl_if ();

   vga_timing u_timing (
      .pclk     (pclk),
      .rst      (rst),
      .h_cnt_o  (h_cnt),
      .v_cnt_o  (v_cnt),
      .active_o (active),
      .hsync_o  (hsync_raw),
      .vsync_o  (vsync_raw)
   );

   entry_fsm u_fsm (
      .pclk    (pclk),
      .rst     (rst),
      .enter_i (enter_i),
      .ctrl    (ctrl_if.sequencer)
   );

   tile_store u_store (
      .pclk         (pclk),
      .rst          (rst),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .ctrl         (ctrl_if.store),
      .tile_codes_o (tile_codes)
   );

   tile_renderer u_render (
      .pclk         (pclk),
      .rst          (rst),
      .h_cnt_i      (h_cnt),
      .v_cnt_i      (v_cnt),
      .active_i     (active),
      .hsync_i      (hsync_raw),
      .vsync_i      (vsync_raw),
      .cursor_i     (cursor_i),
      .state_i      (ctrl_if.state),
      .tile_codes_i (tile_codes),
      .rgb_o        (rgb),
      .hsync_o      (hsync_o),
      .vsync_o      (vsync_o)
   );

   assign state_o = ctrl_if.state;
   assign {vga_red_o, vga_green_o, vga_blue_o} = rgb;

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
screen_pkg.sv
entry_ctrl_if.sv
vga_timing.sv
entry_fsm.sv
tile_store.sv
tile_renderer.sv
screen_top.sv
tb_screen.sv

// File: tb_screen.sv
`default_nettype none

`include "screen_config.svh"

module tb_screen;
   timeunit 1ns;
   timeprecision 1ps;

   import screen_pkg::*;

   localparam int TOTAL_PIX = `H_TOTAL * `V_TOTAL;
   localparam int CYCLE_LIMIT = 3 * TOTAL_PIX + 20000;
   localparam int GRID_ROWS = `NUM_TILES / `GRID_COLS;

   logic pclk;
   logic rst;
   logic enter;
   tile_idx_t cursor;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat_w;
   wb_dat_t wb_dat_r;
   logic wb_ack;
   entry_state_t state;
   logic hsync;
   logic vsync;
   logic [3:0] red;
   logic [3:0] green;
   logic [3:0] blue;

   // reference model
   color_code_t live_m [`NUM_TILES];
   color_code_t saved_m [`NUM_TILES];
   entry_state_t state_m;
   logic [31:0] rng;
   int cycles;

   screen_top UUT (
      .pclk        (pclk),
      .rst         (rst),
      .enter_i     (enter),
      .cursor_i    (cursor),
      .wb_cyc_i    (wb_cyc),
      .wb_stb_i    (wb_stb),
      .wb_we_i     (wb_we),
      .wb_adr_i    (wb_adr),
      .wb_dat_i    (wb_dat_w),
      .wb_dat_o    (wb_dat_r),
      .wb_ack_o    (wb_ack),
      .state_o     (state),
      .hsync_o     (hsync),
      .vsync_o     (vsync),
      .vga_red_o   (red),
      .vga_green_o (green),
      .vga_blue_o  (blue)
   );

   initial begin
      pclk = 1'b0;
      forever #50 pclk = ~pclk;
   end

   // raster position since reset release and the watchdog
   always @(posedge pclk) begin
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Something failed");
         $fatal(1, "watchdog expired");
      end else if (rst) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic next_cycle();
      @(posedge pclk);
      #10;
   endtask

   function automatic rgb_t palette(input color_code_t code);
      case (code)
         3'd0: return 12'hf00;
         3'd1: return 12'h0f0;
         3'd2: return 12'h00f;
         3'd3: return 12'hfff;
         3'd4: return 12'hf90;
         3'd5: return 12'hff0;
         default: return 12'h000;
      endcase
   endfunction

   function automatic rgb_t expected_pixel(input int h, input int v);
      int col;
      int row;
      int ox;
      int oy;
      int tile;
      logic edge_px;
      if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
         return 12'h000;
      end
      if (h < `GRID_X0 || h >= `GRID_X0 + `GRID_COLS * `TILE_SIZE ||
          v < `GRID_Y0 || v >= `GRID_Y0 + GRID_ROWS * `TILE_SIZE) begin
         return 12'hffc;
      end
      col = (h - `GRID_X0) / `TILE_SIZE;
      row = (v - `GRID_Y0) / `TILE_SIZE;
      ox = (h - `GRID_X0) % `TILE_SIZE;
      oy = (v - `GRID_Y0) % `TILE_SIZE;
      tile = row * `GRID_COLS + col;
      edge_px = (ox < `BORDER) || (ox >= `TILE_SIZE - `BORDER) ||
                (oy < `BORDER) || (oy >= `TILE_SIZE - `BORDER);
      if (!edge_px) begin
         return palette(live_m[tile]);
      end
      if (tile == cursor && (state_m == ENTER_FRONT || state_m == ENTER_BACK)) begin
         return 12'h60c;
      end
      return 12'h000;
   endfunction

   function automatic logic [31:0] expected_read(input int adr);
      if (adr < `NUM_TILES) begin
         return {29'd0, live_m[adr]};
      end
      if (adr >= 16 && adr < 16 + `NUM_TILES) begin
         return {29'd0, saved_m[adr - 16]};
      end
      return 32'd0;
   endfunction

   function automatic logic all_tiles_set();
      foreach (live_m[i]) begin
         if (live_m[i] == 3'd7) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   ////////////////////////////////////////
   // bus and entry tasks
   ////////////////////////////////////////
   task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            output wb_dat_t rdata);
      int waited;
      waited = 0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = dat;
      do begin
         next_cycle();
         waited++;
      end while (wb_ack !== 1'b1);
      check("ack latency", 1, waited);
      rdata = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      next_cycle();
      check("ack width", 0, wb_ack);
   endtask

   task automatic write_tile(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      bus_cycle(1'b1, adr, dat, unused);
      if (adr < `NUM_TILES && (state_m == ENTER_FRONT || state_m == ENTER_BACK)) begin
         live_m[adr] = dat[2:0];
      end
   endtask

   task automatic read_check(input wb_adr_t adr);
      wb_dat_t rdata;
      bus_cycle(1'b0, adr, '0, rdata);
      check($sformatf("read adr %0d", adr), expected_read(adr), rdata);
   endtask

   task automatic read_all();
      for (int a = 0; a < 32; a++) begin
         read_check(wb_adr_t'(a));
      end
   endtask

   task automatic random_writes(input int count);
      logic [31:0] r;
      repeat (count) begin
         r = next_random();
         write_tile(r[4:0], r[12:5]);
         read_check(r[4:0]);
      end
   endtask

   // codes 0 to 6 only, so every tile ends up set
   task automatic fill_live();
      logic [31:0] r;
      for (int i = 0; i < `NUM_TILES; i++) begin
         r = next_random();
         write_tile(wb_adr_t'(i), {r[7:3], 3'((r >> 8) % 7)});
      end
   endtask

   task automatic pulse_enter();
      logic advance;
      advance = all_tiles_set();
      enter = 1'b1;
      next_cycle();
      enter = 1'b0;
      if (advance && state_m == ENTER_FRONT) begin
         check("state in clear", CLEAR, state);
         next_cycle();
         saved_m = live_m;
         foreach (live_m[i]) begin
            live_m[i] = 3'd7;
         end
         state_m = ENTER_BACK;
      end else if (advance && state_m == ENTER_BACK) begin
         state_m = DONE;
      end
      check("state after enter", state_m, state);
   endtask

   // output at a sample shows the position the timer held one cycle earlier
   task automatic check_frame();
      int p;
      int h;
      int v;
      logic hs;
      logic vs;
      repeat (TOTAL_PIX) begin
         next_cycle();
         p = (cycles - 1) % TOTAL_PIX;
         h = p % `H_TOTAL;
         v = p / `H_TOTAL;
         hs = !(h >= `H_ACTIVE + `H_FRONT && h < `H_ACTIVE + `H_FRONT + `H_SYNC);
         vs = !(v >= `V_ACTIVE + `V_FRONT && v < `V_ACTIVE + `V_FRONT + `V_SYNC);
         check($sformatf("pixel h=%0d v=%0d", h, v), {hs, vs, expected_pixel(h, v)},
               {hsync, vsync, red, green, blue});
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      rng = 32'h1e60_0d79;
      rst = 1'b1;
      enter = 1'b0;
      cursor = '0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      foreach (live_m[i]) begin
         live_m[i] = 3'd7;
         saved_m[i] = 3'd7;
      end
      state_m = ENTER_FRONT;

      repeat (3) @(posedge pclk);
      #10;
      check("reset hsync", 1, hsync);
      check("reset vsync", 1, vsync);
      check("reset rgb", 0, {red, green, blue});
      check("reset ack", 0, wb_ack);
      check("reset state", ENTER_FRONT, state);
      rst = 1'b0;

      read_all();
      random_writes(40);

      // enter must be ignored while one tile is still unset
      write_tile(5'd5, 8'h07);
      pulse_enter();
      fill_live();
      pulse_enter();
      read_all();

      // back pass with a frame checked while the cursor frame shows
      fill_live();
      cursor = tile_idx_t'(next_random() % `NUM_TILES);
      next_cycle();
      next_cycle();
      check_frame();
      pulse_enter();
      random_writes(12);
      read_all();

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tile_renderer.sv
`default_nettype none

`include "screen_config.svh"

module tile_renderer (
   input  wire                         pclk,
   input  wire                         rst,
   input  wire screen_pkg::coord_t     h_cnt_i,
   input  wire screen_pkg::coord_t     v_cnt_i,
   input  wire                         active_i,
   input  wire                         hsync_i,
   input  wire                         vsync_i,
   input  wire screen_pkg::tile_idx_t  cursor_i,
   input  var screen_pkg::entry_state_t state_i,
   input  wire screen_pkg::color_code_t tile_codes_i [`NUM_TILES],
   output screen_pkg::rgb_t            rgb_o,
   output logic                        hsync_o,
   output logic                        vsync_o
);
   import screen_pkg::*;

   localparam int GRID_ROWS = `NUM_TILES / `GRID_COLS;
   localparam coord_t GRID_X1 = coord_t'(`GRID_X0 + `GRID_COLS * `TILE_SIZE);
   localparam coord_t GRID_Y1 = coord_t'(`GRID_Y0 + GRID_ROWS * `TILE_SIZE);
   localparam coord_t EDGE_LO = coord_t'(`BORDER);
   localparam coord_t EDGE_HI = coord_t'(`TILE_SIZE - `BORDER);

   coord_t dx;
   coord_t dy;
   coord_t ox;
   coord_t oy;
   tile_idx_t col;
   tile_idx_t row;
   tile_idx_t tile;
   logic in_grid;
   logic on_border;
   logic show_cursor;
   rgb_t pix;

   ////////////////////////////////////////
   // pixel to tile
   ////////////////////////////////////////
   always_comb begin
      dx = h_cnt_i - coord_t'(`GRID_X0);
      dy = v_cnt_i - coord_t'(`GRID_Y0);
      col = '0;
      row = '0;
      ox = dx;
      oy = dy;
      // step across tile boundaries instead of dividing
      for (int c = 1; c < `GRID_COLS; c++) begin
         if (dx >= coord_t'(c * `TILE_SIZE)) begin
            col = tile_idx_t'(c);
            ox = dx - coord_t'(c * `TILE_SIZE);
         end
      end
      for (int r = 1; r < GRID_ROWS; r++) begin
         if (dy >= coord_t'(r * `TILE_SIZE)) begin
            row = tile_idx_t'(r);
            oy = dy - coord_t'(r * `TILE_SIZE);
         end
      end
      // row-major from top left
      tile = tile_idx_t'(row * `GRID_COLS + col);
   end

   assign in_grid = (h_cnt_i >= coord_t'(`GRID_X0)) && (h_cnt_i < GRID_X1) &&
                    (v_cnt_i >= coord_t'(`GRID_Y0)) && (v_cnt_i < GRID_Y1);

   assign on_border = (ox < EDGE_LO) || (ox >= EDGE_HI) ||
                      (oy < EDGE_LO) || (oy >= EDGE_HI);

   // cursor frame only while tiles are being entered
   assign show_cursor = (tile == cursor_i) &&
                        ((state_i == ENTER_FRONT) || (state_i == ENTER_BACK));

   always_comb begin
      if (!active_i) begin
         pix = '0;
      end else if (!in_grid) begin
         pix = BACKGROUND;
      end else if (on_border) begin
         pix = show_cursor ? HIGHLIGHT : rgb_t'(0);
      end else begin
         pix = color_to_rgb(tile_codes_i[tile]);
      end
   end

   // one stage, syncs ride along with the colour
   always_ff @(posedge pclk or posedge rst) begin
      if (rst) begin
         rgb_o <= '0;
         hsync_o <= 1'b1;
         vsync_o <= 1'b1;
      end else begin
         rgb_o <= pix;
         hsync_o <= hsync_i;
         vsync_o <= vsync_i;
      end
   end

endmodule

`default_nettype wire

// File: tile_store.sv
`default_nettype none

`include "screen_config.svh"

module tile_store (
   input  wire                     pclk,
   input  wire                     rst,
   input  wire                     wb_cyc_i,
   input  wire                     wb_stb_i,
   input  wire                     wb_we_i,
   input  wire screen_pkg::wb_adr_t wb_adr_i,
   input  wire screen_pkg::wb_dat_t wb_dat_i,
   output screen_pkg::wb_dat_t     wb_dat_o,
   output logic                    wb_ack_o,
   entry_ctrl_if.store             ctrl,
   output screen_pkg::color_code_t tile_codes_o [`NUM_TILES]
);
   import screen_pkg::*;

   color_code_t live_q [`NUM_TILES];
   color_code_t saved_q [`NUM_TILES];

   tile_idx_t idx;
   logic bank_sel;
   logic idx_ok;
   logic req;
   logic wr_open;
   logic wr_en;
   color_code_t rd_code;

   ////////////////////////////////////////
   // wishbone decode
   ////////////////////////////////////////

   // new request only while ack is low, so ack stays one cycle wide
   assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

   // bit 4 picks the saved bank
   assign bank_sel = wb_adr_i[4];
   assign idx = wb_adr_i[3:0];
   assign idx_ok = (idx < tile_idx_t'(`NUM_TILES));

   assign wr_open = (ctrl.state == ENTER_FRONT) || (ctrl.state == ENTER_BACK);
   assign wr_en = req && wb_we_i && !bank_sel && idx_ok && wr_open;

   always_comb begin
      rd_code = '0;
      if (idx_ok) begin
         rd_code = bank_sel ? saved_q[idx] : live_q[idx];
      end
   end

   always_ff @(posedge pclk or posedge rst) begin
      if (rst) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= req;
      end
   end

   // read data only matters while ack is high
   always_ff @(posedge pclk) begin
      if (req) begin
         wb_dat_o <= wb_dat_t'(rd_code);
      end
   end

   ////////////////////////////////////////
   // tile banks
   ////////////////////////////////////////

   // save and clear win over a bus write on the same edge
   always_ff @(posedge pclk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `NUM_TILES; i++) begin
            live_q[i] <= UNSET_CODE;
            saved_q[i] <= UNSET_CODE;
         end
      end else if (ctrl.save || ctrl.clear) begin
         for (int i = 0; i < `NUM_TILES; i++) begin
            if (ctrl.save) begin
               saved_q[i] <= live_q[i];
            end
            if (ctrl.clear) begin
               live_q[i] <= UNSET_CODE;
            end
         end
      end else if (wr_en) begin
         live_q[idx] <= color_code_t'(wb_dat_i[2:0]);
      end
   end

   always_comb begin
      ctrl.all_set = 1'b1;
      for (int i = 0; i < `NUM_TILES; i++) begin
         if (live_q[i] == UNSET_CODE) begin
            ctrl.all_set = 1'b0;
         end
      end
   end

   assign tile_codes_o = live_q;

endmodule

`default_nettype wire

// File: vga_timing.sv
`default_nettype none

`include "screen_config.svh"

module vga_timing (
   input  wire                pclk,
   input  wire                rst,
   output screen_pkg::coord_t h_cnt_o,
   output screen_pkg::coord_t v_cnt_o,
   output logic               active_o,
   output logic               hsync_o,
   output logic               vsync_o
);
   import screen_pkg::*;

   localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
   localparam coord_t HS_END = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
   localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
   localparam coord_t VS_END = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

   coord_t h_q;
   coord_t v_q;
   coord_t h_next;
   coord_t v_next;
   logic h_wrap;
   logic v_wrap;

   always_comb begin
      h_wrap = (h_q == coord_t'(`H_TOTAL - 1));
      v_wrap = (v_q == coord_t'(`V_TOTAL - 1));
      h_next = h_wrap ? '0 : h_q + 1'b1;
      v_next = v_q;
      if (h_wrap) begin
         v_next = v_wrap ? '0 : v_q + 1'b1;
      end
   end

   // sync flops look at the next count so they line up with h_q and v_q
   always_ff @(posedge pclk or posedge rst) begin
      if (rst) begin
         h_q <= '0;
         v_q <= '0;
         hsync_o <= 1'b1;
         vsync_o <= 1'b1;
      end else begin
         h_q <= h_next;
         v_q <= v_next;
         hsync_o <= !((h_next >= HS_START) && (h_next < HS_END));
         vsync_o <= !((v_next >= VS_START) && (v_next < VS_END));
      end
   end

   assign h_cnt_o = h_q;
   assign v_cnt_o = v_q;

   // visible area
   assign active_o = (h_q < coord_t'(`H_ACTIVE)) && (v_q < coord_t'(`V_ACTIVE));

endmodule

`default_nettype wire
